//--- include/drive_params.svh
`ifndef DRIVE_PARAMS_SVH
`define DRIVE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drive controller constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width shared by duty and speed. Full scale is 1023.
`define DRIVE_DUTY_W 10

// 25 kHz with a 100 MHz clock.
`define DRIVE_PWM_PERIOD 4000

// Largest duty change in one PWM period.
`define DRIVE_RAMP_STEP 64

// Flops in front of the request edge detector.
`define DRIVE_SYNC_STAGES 2

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build the drive controller testbench with Verilator and run it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module drive_tb \
    -o drive_sim

./obj_dir/drive_sim | tee sim.log

# The log decides the result.
if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- source/cmd_receiver.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module cmd_receiver (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_req,
    input  motion_cmd_pkg::drive_cmd_t cmd,
    output logic                       cmd_ack,
    output motion_cmd_pkg::drive_cmd_t cmd_latched,
    output logic                       cmd_valid
);

    localparam int last_stage = `DRIVE_SYNC_STAGES - 1;

    logic [`DRIVE_SYNC_STAGES-1:0] req_sync;
    logic                          req_prev;
    logic                          req_rise;
    logic                          latch_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request synchronizer and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_rise = req_sync[last_stage] & ~req_prev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_sync <= '0;
            req_prev <= 1'b0;
        end else begin
            req_sync <= {req_sync[last_stage-1:0], cmd_req};
            req_prev <= req_sync[last_stage];
        end
    end

    // cmd is held stable by the host while the request is up.
    always_ff @(posedge clk) begin
        if (req_rise) begin
            cmd_latched <= cmd;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Four-phase acknowledge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            latch_done <= 1'b0;
            cmd_valid  <= 1'b0;
            cmd_ack    <= 1'b0;
        end else begin
            latch_done <= req_rise;
            cmd_valid  <= latch_done;                // Pulses once with the ack rise.
            if (latch_done) begin
                cmd_ack <= 1'b1;
            end else if (!req_sync[last_stage]) begin
                cmd_ack <= 1'b0;                     // Host has dropped the request.
            end
        end
    end

endmodule

//--- source/drive_top.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module drive_top #(
    parameter int pwm_period = `DRIVE_PWM_PERIOD
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_req,
    input  motion_cmd_pkg::drive_cmd_t cmd,
    output logic                       cmd_ack,
    output logic                       pwm_left,
    output logic                       pwm_right,
    output wheel_pkg::wheel_dir_e      dir_left,
    output wheel_pkg::wheel_dir_e      dir_right,
    output logic                       settled
);

    import motion_cmd_pkg::*;
    import wheel_pkg::*;

    drive_cmd_t  cmd_latched;
    logic        cmd_valid;
    wheel_pair_t target;
    wheel_set_t  setpoint_left;
    wheel_set_t  setpoint_right;
    logic        at_target_left;
    logic        at_target_right;
    logic        period_start_left;
    logic        period_start_right;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cmd_receiver cmd_receiver_i (
        .clk, .reset, .cmd_req, .cmd, .cmd_ack, .cmd_latched, .cmd_valid
    );

    motion_mixer motion_mixer_i (
        .clk, .reset, .cmd_latched, .cmd_valid, .target
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wheels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    speed_ramp ramp_left_i (
        .clk, .reset, .target(target.left), .period_start(period_start_left),
        .setpoint(setpoint_left), .at_target(at_target_left)
    );

    speed_ramp ramp_right_i (
        .clk, .reset, .target(target.right), .period_start(period_start_right),
        .setpoint(setpoint_right), .at_target(at_target_right)
    );

    wheel_pwm #(.pwm_period(pwm_period)) pwm_left_i (
        .clk, .reset, .duty(setpoint_left.duty), .pwm(pwm_left),
        .period_start(period_start_left)
    );

    wheel_pwm #(.pwm_period(pwm_period)) pwm_right_i (
        .clk, .reset, .duty(setpoint_right.duty), .pwm(pwm_right),
        .period_start(period_start_right)
    );

    assign dir_left  = setpoint_left.dir;
    assign dir_right = setpoint_right.dir;
    assign settled   = at_target_left & at_target_right;   // Both ramps done.

endmodule

//--- source/motion_cmd_pkg.sv
`include "drive_params.svh"

package motion_cmd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host command types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Codes 5 to 7 are not named and act as stop.
    typedef enum logic [2:0] {
        STOP       = 3'd0,
        FORWARD    = 3'd1,
        TURN_RIGHT = 3'd2,
        TURN_LEFT  = 3'd3,
        BACKWARD   = 3'd4
    } drive_mode_e;

    // One motion command as posted by the host.
    typedef struct packed {
        drive_mode_e               mode;   // Mode in the top bits.
        logic [`DRIVE_DUTY_W-1:0]  speed;  // Duty for the driven wheels.
    } drive_cmd_t;

endpackage

//--- source/motion_mixer.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module motion_mixer (
    input  logic                       clk,
    input  logic                       reset,
    input  motion_cmd_pkg::drive_cmd_t cmd_latched,
    input  logic                       cmd_valid,
    output wheel_pkg::wheel_pair_t     target
);

    import motion_cmd_pkg::*;
    import wheel_pkg::*;

    wheel_pair_t mix;

    function automatic wheel_set_t make_set(
        input wheel_dir_e               dir,
        input logic [`DRIVE_DUTY_W-1:0] duty
    );
        wheel_set_t set;
        set.dir  = dir;
        set.duty = duty;
        return set;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (cmd_latched.mode)
            FORWARD: begin
                mix.left  = make_set(FWD, cmd_latched.speed);
                mix.right = make_set(FWD, cmd_latched.speed);
            end
            BACKWARD: begin
                mix.left  = make_set(REV, cmd_latched.speed);   // Both wheels reversed.
                mix.right = make_set(REV, cmd_latched.speed);
            end
            TURN_RIGHT: begin
                mix.left  = make_set(FWD, cmd_latched.speed);
                mix.right = make_set(FWD, '0);
            end
            TURN_LEFT: begin
                mix.left  = make_set(FWD, '0);
                mix.right = make_set(FWD, cmd_latched.speed);
            end
            default: begin
                mix.left  = make_set(FWD, '0);                   // Stop and codes 5 to 7.
                mix.right = make_set(FWD, '0);
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            target <= '0;
        end else if (cmd_valid) begin
            target <= mix;
        end
    end

endmodule

//--- source/speed_ramp.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module speed_ramp (
    input  logic                  clk,
    input  logic                  reset,
    input  wheel_pkg::wheel_set_t target,
    input  logic                  period_start,
    output wheel_pkg::wheel_set_t setpoint,
    output logic                  at_target
);

    import wheel_pkg::*;

    localparam logic [`DRIVE_DUTY_W-1:0] ramp_step = `DRIVE_RAMP_STEP;

    logic [`DRIVE_DUTY_W-1:0] up_gap;
    logic [`DRIVE_DUTY_W-1:0] down_gap;
    wheel_set_t               next_set;

    assign up_gap   = target.duty - setpoint.duty;
    assign down_gap = setpoint.duty - target.duty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next setpoint with one step per PWM period
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_set = setpoint;
        if (target.dir != setpoint.dir) begin
            // Run down to zero before the flip to protect the H-bridge.
            if (setpoint.duty == '0) begin
                next_set.dir = target.dir;                   // Duty stays zero here.
            end else if (setpoint.duty > ramp_step) begin
                next_set.duty = setpoint.duty - ramp_step;
            end else begin
                next_set.duty = '0;
            end
        end else if (target.duty > setpoint.duty) begin
            if (up_gap > ramp_step) begin
                next_set.duty = setpoint.duty + ramp_step;
            end else begin
                next_set.duty = target.duty;                 // Clipped so it never overshoots.
            end
        end else if (target.duty < setpoint.duty) begin
            if (down_gap > ramp_step) begin
                next_set.duty = setpoint.duty - ramp_step;
            end else begin
                next_set.duty = target.duty;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            setpoint <= '0;
        end else if (period_start) begin
            setpoint <= next_set;
        end
    end

    assign at_target = (setpoint == target);

endmodule

//--- source/wheel_pkg.sv
`include "drive_params.svh"

package wheel_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-wheel setpoint types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        FWD = 1'b0,
        REV = 1'b1
    } wheel_dir_e;

    // Direction and duty of one wheel.
    typedef struct packed {
        wheel_dir_e                dir;
        logic [`DRIVE_DUTY_W-1:0]  duty;
    } wheel_set_t;

    // Both wheels with the left one in the upper half.
    typedef struct packed {
        wheel_set_t left;
        wheel_set_t right;
    } wheel_pair_t;

endpackage

//--- source/wheel_pwm.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module wheel_pwm #(
    parameter int pwm_period = `DRIVE_PWM_PERIOD
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`DRIVE_DUTY_W-1:0] duty,
    output logic                     pwm,
    output logic                     period_start
);

    localparam int cnt_w  = (pwm_period > 1) ? $clog2(pwm_period) : 1;
    localparam int prod_w = cnt_w + `DRIVE_DUTY_W;

    localparam logic [cnt_w-1:0]  last_count = cnt_w'(pwm_period - 1);
    localparam logic [prod_w-1:0] period_ext = prod_w'(pwm_period);

    logic [cnt_w-1:0]  count;
    logic [prod_w-1:0] product;
    logic [cnt_w-1:0]  high_new;
    logic [cnt_w-1:0]  high_time;
    logic [cnt_w-1:0]  high_now;

    // Strobe on the last count, so the ramp's new duty is there at count 0.
    assign period_start = (count == last_count);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // High time as period * duty / 1024
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign product  = period_ext * prod_w'(duty);
    assign high_new = product[prod_w-1:`DRIVE_DUTY_W];                // Rounds down.
    assign high_now = (count == '0) ? high_new : high_time;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= last_count;                    // First cycle out of reset strobes.
            high_time <= '0;
            pwm       <= 1'b0;
        end else begin
            if (period_start) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            if (count == '0) begin
                high_time <= high_new;                  // Held for the whole period.
            end
            pwm <= (count < high_now);
        end
    end

endmodule

//--- src.f
+incdir+include
source/motion_cmd_pkg.sv
source/wheel_pkg.sv
source/cmd_receiver.sv
source/motion_mixer.sv
source/speed_ramp.sv
source/wheel_pwm.sv
source/drive_top.sv
tests/drive_checks.sv
tests/drive_tb.sv

//--- tests/drive_checks.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module drive_checks #(
    parameter int pwm_period = `DRIVE_PWM_PERIOD
) (
    input logic                       clk,
    input logic                       reset,
    input logic                       cmd_req,
    input motion_cmd_pkg::drive_cmd_t cmd,
    input logic                       cmd_ack,
    input logic                       pwm_left,
    input logic                       pwm_right,
    input wheel_pkg::wheel_dir_e      dir_left,
    input wheel_pkg::wheel_dir_e      dir_right,
    input logic                       settled
);

    import motion_cmd_pkg::*;
    import wheel_pkg::*;

    typedef logic [`DRIVE_DUTY_W-1:0] duty_t;

    localparam int step       = `DRIVE_RAMP_STEP;
    localparam int max_change = (pwm_period * step + 1023) / 1024;

    int unsigned fail_count = 0;
    int          phase;
    logic        ack_prev;
    wheel_pair_t exp_target;
    wheel_pair_t shadow;
    int          high_l;
    int          high_r;
    int          win_duty_l;
    int          win_duty_r;
    int          last_high_l;
    int          last_high_r;
    logic        win_open;
    logic        have_last;
    int          low_run_l;
    int          low_run_r;
    wheel_dir_e  dir_prev_l;
    wheel_dir_e  dir_prev_r;

    function automatic void report_fail(input string msg);
        $error("[FAIL] %0t: %s", $time, msg);
        fail_count++;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic wheel_pair_t mix_rule(input drive_cmd_t c);
        wheel_pair_t p;
        p = '0;
        if (c.mode == FORWARD || c.mode == TURN_RIGHT || c.mode == BACKWARD) begin
            p.left.duty = c.speed;
        end
        if (c.mode == FORWARD || c.mode == TURN_LEFT || c.mode == BACKWARD) begin
            p.right.duty = c.speed;
        end
        if (c.mode == BACKWARD) begin
            p.left.dir  = REV;
            p.right.dir = REV;
        end
        return p;
    endfunction

    function automatic wheel_set_t next_shadow(input wheel_set_t cur, input wheel_set_t tgt);
        wheel_set_t nxt;
        int         d;
        int         t;
        nxt = cur;
        d   = int'(cur.duty);
        t   = int'(tgt.duty);
        if (cur.dir != tgt.dir) begin
            if (d == 0) begin
                nxt.dir = tgt.dir;                                   // Flip only at zero.
            end else begin
                nxt.duty = duty_t'((d > step) ? d - step : 0);
            end
        end else if (t > d) begin
            nxt.duty = duty_t'((t - d > step) ? d + step : t);
        end else if (t < d) begin
            nxt.duty = duty_t'((d - t > step) ? d - step : t);
        end
        return nxt;
    endfunction

    task automatic check_window(input string wheel, input int high, input int duty,
                                input int last, input logic have);
        int want;
        want = (pwm_period * duty) / 1024;
        assert (high == want)
            else report_fail($sformatf("%s high time %0d, expected %0d", wheel, high, want));
        if (have) begin
            assert (high - last <= max_change && last - high <= max_change)
                else report_fail($sformatf("%s high time jumped %0d to %0d", wheel, last, high));
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= pwm_period - 1;                            // First edge out of reset.
            ack_prev   <= 1'b0;
            exp_target <= '0;
            shadow     <= '0;
            high_l     <= 0;
            high_r     <= 0;
            win_duty_l <= 0;
            win_duty_r <= 0;
            win_open   <= 1'b0;
            have_last  <= 1'b0;
            low_run_l  <= 0;
            low_run_r  <= 0;
            dir_prev_l <= FWD;
            dir_prev_r <= FWD;
        end else begin
            assert (dir_left == shadow.left.dir && dir_right == shadow.right.dir)
                else report_fail("direction differs from the shadow ramp");
            assert (settled == (shadow == exp_target))
                else report_fail($sformatf("settled is %0b, model says %0b",
                                           settled, shadow == exp_target));
            ack_prev <= cmd_ack;
            if (cmd_ack && !ack_prev) begin
                exp_target <= mix_rule(cmd);                         // Target follows ack by one.
            end
            if (phase == pwm_period - 1) begin
                phase        <= 0;
                shadow.left  <= next_shadow(shadow.left, exp_target.left);
                shadow.right <= next_shadow(shadow.right, exp_target.right);
            end else begin
                phase <= phase + 1;
            end

            // PWM lags the counter, so a window runs from phase 1 to phase 0.
            if (phase == 1) begin
                high_l     <= int'(pwm_left);
                high_r     <= int'(pwm_right);
                win_duty_l <= int'(shadow.left.duty);
                win_duty_r <= int'(shadow.right.duty);
                win_open   <= 1'b1;
            end else begin
                high_l <= high_l + int'(pwm_left);
                high_r <= high_r + int'(pwm_right);
            end
            if (phase == 0 && win_open) begin
                check_window("left", high_l + int'(pwm_left), win_duty_l, last_high_l, have_last);
                check_window("right", high_r + int'(pwm_right), win_duty_r, last_high_r,
                             have_last);
                last_high_l <= high_l + int'(pwm_left);
                last_high_r <= high_r + int'(pwm_right);
                have_last   <= 1'b1;
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Reversal through a dark period
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            low_run_l  <= pwm_left ? 0 : ((low_run_l < pwm_period) ? low_run_l + 1 : low_run_l);
            low_run_r  <= pwm_right ? 0 : ((low_run_r < pwm_period) ? low_run_r + 1 : low_run_r);
            dir_prev_l <= dir_left;
            dir_prev_r <= dir_right;
            if (dir_left != dir_prev_l) begin
                assert (!pwm_left && low_run_l >= pwm_period - 1)
                    else report_fail("left wheel reversed while driven");
            end
            if (dir_right != dir_prev_r) begin
                assert (!pwm_right && low_run_r >= pwm_period - 1)
                    else report_fail("right wheel reversed while driven");
            end
        end
    end

    // Ack rises 3 clocks after the first high sample of the request.
    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ack) |-> $past(cmd_req) && $past(cmd_req, 4) && !$past(cmd_req, 5))
        else report_fail("cmd_ack rise not 3 clocks after request");

    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(cmd_ack) |-> !$past(cmd_req) && !$past(cmd_req, 3) && $past(cmd_req, 4))
        else report_fail("cmd_ack fall not 2 clocks after request drop");

endmodule

//--- tests/drive_tb.sv
`timescale 1ns/1ps
`include "drive_params.svh"

module drive_tb;

    import motion_cmd_pkg::*;
    import wheel_pkg::*;

    localparam int period_clks     = 64;
    localparam int clk_ns          = 20;
    localparam int cmd_count       = 14;                 // Commands over all tests.
    localparam int periods_per_cmd = 40;                 // Full reversal needs 33.
    localparam int watchdog_ns     = cmd_count * periods_per_cmd * period_clks * clk_ns + 20000;

    logic        clk = 1'b0;
    logic        reset;
    logic        cmd_req;
    drive_cmd_t  cmd;
    logic        cmd_ack;
    logic        pwm_left;
    logic        pwm_right;
    wheel_dir_e  dir_left;
    wheel_dir_e  dir_right;
    logic        settled;

    int unsigned tb_fails = 0;
    int unsigned tests_run = 0;
    int unsigned fails_before = 0;
    string       test_name = "reset";

    drive_top #(.pwm_period(period_clks)) dut_i (
        .clk, .reset, .cmd_req, .cmd, .cmd_ack, .pwm_left, .pwm_right,
        .dir_left, .dir_right, .settled
    );

    bind drive_top drive_checks #(.pwm_period(pwm_period)) checks_i (
        .clk(clk), .reset(reset), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
        .pwm_left(pwm_left), .pwm_right(pwm_right), .dir_left(dir_left),
        .dir_right(dir_right), .settled(settled)
    );

    always #10 clk = ~clk;

    function automatic int unsigned total_fails();
        return tb_fails + dut_i.checks_i.fail_count;
    endfunction

    function automatic void note_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        tb_fails++;
    endfunction

    task automatic begin_test(input string name);
        test_name    = name;
        fails_before = total_fails();
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d new errors", test_name,
                 total_fails() - fails_before);
        tests_run++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side of the four-phase handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_cmd(input logic [2:0] mode_code,
                            input logic [`DRIVE_DUTY_W-1:0] speed);
        @(negedge clk);
        cmd     = drive_cmd_t'({mode_code, speed});
        cmd_req = 1'b1;
        while (!cmd_ack) @(negedge clk);
        cmd_req = 1'b0;
        while (cmd_ack) @(negedge clk);                  // Target is loaded by now.
    endtask

    task automatic wait_settled();
        while (!settled) @(negedge clk);
        repeat (3 * period_clks) @(negedge clk);         // Let settled windows be checked.
    endtask

    task automatic run_modes();
        logic [2:0] codes [8];
        logic [2:0] tmp;
        int         i;
        int         j;
        for (i = 0; i < 8; i++) begin
            codes[i] = 3'(i);
        end
        for (i = 7; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = codes[i];
            codes[i] = codes[j];
            codes[j] = tmp;
        end
        for (i = 0; i < 8; i++) begin
            send_cmd(codes[i], 10'($urandom % 1024));
            wait_settled();
        end
    endtask

    initial begin
        void'($urandom(2761));
        reset      = 1'b1;
        cmd_req    = 1'b0;
        cmd        = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!cmd_ack && !pwm_left && !pwm_right && dir_left == FWD && dir_right == FWD
                && settled)
            else note_fail("outputs not at their reset values");
        finish_test();

        begin_test("modes");
        run_modes();
        finish_test();

        begin_test("reversal");
        send_cmd(3'd1, 10'd1023);
        wait_settled();
        send_cmd(3'd4, 10'd1023);
        wait_settled();
        assert (dir_left == REV && dir_right == REV)
            else note_fail($sformatf("backward gave dirs %0d/%0d", dir_left, dir_right));
        finish_test();

        begin_test("retarget");
        send_cmd(3'd0, 10'd0);
        wait_settled();
        send_cmd(3'd1, 10'd1000);
        repeat (4 * period_clks) @(negedge clk);
        assert (!settled) else note_fail("settled high in the middle of a ramp");
        send_cmd(3'd3, 10'd200);
        repeat (3 * period_clks) @(negedge clk);
        send_cmd(3'd4, 10'd500);
        wait_settled();
        finish_test();

        $display("Summary: %0d tests run, %0d errors", tests_run, total_fails());
        if (total_fails() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, test %s did not finish in time", test_name);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
